/* verilog/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    localparam int DATA_W  = 32;
    localparam int DEST_W  = 2;
    localparam int PRIO_W  = 2;
    localparam int LEN_W   = 5;
    localparam int LEN_MAX = 16;
    localparam int CRC_W   = 16;

    localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;
    localparam logic [CRC_W-1:0] CRC_INIT = 16'hFFFF;

    // Header word fields.
    localparam int HDR_LEN_LSB  = 0;
    localparam int HDR_PRIO_LSB = 5;
    localparam int HDR_DEST_LSB = 7;

    // Descriptor word fields, upper bits zero.
    localparam int DSC_CRC_LSB  = 0;
    localparam int DSC_LEN_LSB  = 16;
    localparam int DSC_PRIO_LSB = 21;
    localparam int DSC_DEST_LSB = 23;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        logic [DATA_W-1:0] data;
    } wr_beat_t;

    typedef struct packed {
        logic              vld;
        logic              sop;
        logic              eop;
        logic              src;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] data;
    } out_beat_t;

    typedef struct packed {
        logic              error;
        logic [CRC_W-1:0]  crc;
        logic [DEST_W-1:0] dest;
        logic [PRIO_W-1:0] prio;
        logic [LEN_W-1:0]  len;   // Payload words actually written.
    } pkt_desc_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_SEND} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_DESC, RD_DATA, RD_DROP} rd_state_t;
    typedef enum logic [1:0] {ARB_IDLE, ARB_PORT0, ARB_PORT1} arb_state_t;

endpackage

`default_nettype wire

/* verilog/crc16_word.sv */
`timescale 1ns/1ns
`default_nettype none

module crc16_word
    import switch_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr,
    input  logic              en,
    input  logic [DATA_W-1:0] data_in,
    output logic [CRC_W-1:0]  crc
);

    logic [CRC_W-1:0] crc_nxt;
    logic             fb;

    // 32 serial steps unrolled, MSB first.
    always_comb begin
        crc_nxt = crc;
        fb = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            fb = crc_nxt[CRC_W-1] ^ data_in[i];
            crc_nxt = {crc_nxt[CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (clr) begin
            crc <= CRC_INIT;
        end else if (en) begin
            crc <= crc_nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/dc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module dc_fifo
    import switch_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  logic              rst_n,
    input  logic              wr_clk,
    input  logic              wr_en,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rd_clk,
    input  logic              rd_en,
    output logic [DATA_W-1:0] rd_data,
    output logic              almost_full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW:0]       wr_bin, wr_bin_nxt, wr_gray;
    logic [AW:0]       rd_bin, rd_bin_nxt, rd_gray;
    logic [AW:0]       rd_gray_s1, rd_gray_s2;
    logic [AW:0]       wr_gray_s1, wr_gray_s2;
    logic [AW:0]       used;
    logic              rd_go;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign wr_bin_nxt = wr_bin + 1'b1;
    assign rd_bin_nxt = rd_bin + 1'b1;

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_en) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    // Room for a full packet is required before a new one starts.
    assign used        = wr_bin - gray2bin(rd_gray_s2);
    assign almost_full = used > (AW+1)'(FIFO_DEPTH - LEN_MAX);

    assign rd_go   = rd_en & (rd_gray != wr_gray_s2);   // Never read past empty.
    assign rd_data = mem[rd_bin[AW-1:0]];                // First word falls through.

    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (rd_go) begin
                rd_bin  <= rd_bin_nxt;
                rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cdc_handshake.sv */
`timescale 1ns/1ns
`default_nettype none

module cdc_handshake
    import switch_pkg::*;
(
    input  logic      rst_n,
    input  logic      tx_clk,
    input  logic      rx_clk,
    input  logic      tx_valid,
    input  pkt_desc_t data_in,
    output logic      tx_ready,
    output logic      rx_valid,
    input  logic      rx_ready,
    output pkt_desc_t data_out
);

    pkt_desc_t data_q;
    logic      req, busy, ack_s1, ack_s2;
    logic      ack, req_s1, req_s2;

    // Source side. data_q only changes while idle.
    always_ff @(posedge tx_clk) begin
        if (tx_valid && !busy) begin
            data_q <= data_in;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (!rst_n) begin
            req    <= 1'b0;
            busy   <= 1'b0;
            ack_s1 <= 1'b0;
            ack_s2 <= 1'b0;
        end else begin
            ack_s1 <= ack;
            ack_s2 <= ack_s1;
            if (tx_valid && !busy) begin
                req  <= ~req;
                busy <= 1'b1;
            end else if (busy && ack_s2 == req) begin
                busy <= 1'b0;
            end
        end
    end

    assign tx_ready = ~busy;

    always_ff @(posedge rx_clk) begin
        if (!rst_n) begin
            req_s1 <= 1'b0;
            req_s2 <= 1'b0;
            ack    <= 1'b0;
        end else begin
            req_s1 <= req;
            req_s2 <= req_s1;
            if (rx_ready) begin
                ack <= req_s2;
            end
        end
    end

    assign rx_valid = req_s2 ^ ack;
    assign data_out = data_q;

endmodule

`default_nettype wire

/* verilog/in_wr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module in_wr_ctrl
    import switch_pkg::*;
(
    input  logic             external_clk,
    input  logic             rst_n,
    input  wr_beat_t         wr_in,
    input  logic             fifo_almost_full,
    input  logic             hs_ready,
    input  logic [CRC_W-1:0] crc,
    output logic             crc_clr,
    output logic             crc_en,
    output logic             fifo_wr_en,
    output pkt_desc_t        desc,
    output logic             desc_valid,
    output logic             in_ready
);

    wr_state_t         state;
    logic [LEN_W-1:0]  hdr_len, cnt;
    logic [PRIO_W-1:0] hdr_prio;
    logic [DEST_W-1:0] hdr_dest;
    logic              over, live;
    logic              take_hdr, take_data;

    assign in_ready  = live & (state == WR_IDLE) & hs_ready & ~fifo_almost_full;
    assign take_hdr  = in_ready & wr_in.vld & wr_in.sop;
    assign take_data = (state == WR_DATA) & wr_in.vld;

    always_ff @(posedge external_clk) begin
        if (take_hdr) begin
            hdr_len  <= wr_in.data[HDR_LEN_LSB +: LEN_W];
            hdr_prio <= wr_in.data[HDR_PRIO_LSB +: PRIO_W];
            hdr_dest <= wr_in.data[HDR_DEST_LSB +: DEST_W];
        end
    end

    always_ff @(posedge external_clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
            live  <= 1'b0;
            cnt   <= '0;
            over  <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                WR_IDLE: begin
                    if (take_hdr) begin
                        cnt   <= '0;
                        over  <= 1'b0;
                        state <= wr_in.eop ? WR_SEND : WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (take_data) begin
                        if (cnt == LEN_W'(LEN_MAX)) begin
                            over <= 1'b1;   // Too long, stop writing.
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                        if (wr_in.eop) begin
                            state <= WR_SEND;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    assign fifo_wr_en = take_data & (cnt != LEN_W'(LEN_MAX));
    assign crc_en     = fifo_wr_en;
    assign crc_clr    = take_hdr;
    assign desc_valid = (state == WR_SEND);   // One-cycle pulse.

    assign desc.error = over | (cnt != hdr_len);
    assign desc.crc   = crc;
    assign desc.dest  = hdr_dest;
    assign desc.prio  = hdr_prio;
    assign desc.len   = cnt;

endmodule

`default_nettype wire

/* verilog/in_rd_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module in_rd_ctrl
    import switch_pkg::*;
(
    input  logic              internal_clk,
    input  logic              rst_n,
    input  pkt_desc_t         desc,
    input  logic              desc_valid,
    output logic              desc_ready,
    input  logic [DATA_W-1:0] fifo_rd_data,
    output logic              fifo_rd_en,
    input  logic              grant,
    input  logic              ready,
    output out_beat_t         beat,
    output logic              head
);

    rd_state_t         state;
    pkt_desc_t         d_q;
    logic [LEN_W-1:0]  cnt;
    logic [DATA_W-1:0] desc_word;
    logic              xfer;

    assign desc_ready = (state == RD_IDLE) & desc_valid;
    assign head       = (state == RD_DESC);
    assign xfer       = beat.vld & ready;
    assign fifo_rd_en = (state == RD_DROP) | ((state == RD_DATA) & xfer);

    always_ff @(posedge internal_clk) begin
        if (desc_ready) begin
            d_q <= desc;
        end
    end

    always_ff @(posedge internal_clk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (desc_valid) begin
                        cnt <= desc.len;
                        if (!desc.error) begin
                            state <= RD_DESC;
                        end else if (desc.len != '0) begin
                            state <= RD_DROP;
                        end
                    end
                end
                RD_DESC: begin
                    if (xfer) begin
                        state <= (cnt == '0) ? RD_IDLE : RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (xfer) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == LEN_W'(1)) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                RD_DROP: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == LEN_W'(1)) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_comb begin
        desc_word = '0;
        desc_word[DSC_CRC_LSB +: CRC_W]   = d_q.crc;
        desc_word[DSC_LEN_LSB +: LEN_W]   = d_q.len;
        desc_word[DSC_PRIO_LSB +: PRIO_W] = d_q.prio;
        desc_word[DSC_DEST_LSB +: DEST_W] = d_q.dest;

        beat      = '0;
        beat.vld  = grant & (state == RD_DESC || state == RD_DATA);
        beat.sop  = (state == RD_DESC);
        beat.eop  = ((state == RD_DESC) & (cnt == '0)) |
                    ((state == RD_DATA) & (cnt == LEN_W'(1)));
        beat.dest = d_q.dest;
        beat.data = (state == RD_DESC) ? desc_word : fifo_rd_data;  // Arbiter reads prio here.
    end

endmodule

`default_nettype wire

/* verilog/in_port.sv */
`timescale 1ns/1ns
`default_nettype none

module in_port
    import switch_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  logic      external_clk,
    input  logic      internal_clk,
    input  logic      rst_n,
    input  wr_beat_t  wr_in,
    output logic      in_ready,
    output out_beat_t beat,
    output logic      head,
    input  logic      grant,
    input  logic      ready
);

    logic [CRC_W-1:0]  crc;
    logic              crc_clr, crc_en;
    logic              fifo_wr_en, fifo_rd_en, almost_full;
    logic [DATA_W-1:0] fifo_rd_data;
    pkt_desc_t         wr_desc, rd_desc;
    logic              wr_desc_valid, tx_ready, hs_ready;
    logic              rd_desc_valid, rd_desc_ready;

    // Crossing must be free and no descriptor pending this cycle.
    assign hs_ready = tx_ready & ~wr_desc_valid;

    crc16_word crc16 (
        .clk     (external_clk),
        .rst_n   (rst_n),
        .clr     (crc_clr),
        .en      (crc_en),
        .data_in (wr_in.data),
        .crc     (crc)
    );

    dc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo (
        .rst_n       (rst_n),
        .wr_clk      (external_clk),
        .wr_en       (fifo_wr_en),
        .wr_data     (wr_in.data),
        .rd_clk      (internal_clk),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .almost_full (almost_full)
    );

    cdc_handshake handshake (
        .rst_n    (rst_n),
        .tx_clk   (external_clk),
        .rx_clk   (internal_clk),
        .tx_valid (wr_desc_valid),
        .data_in  (wr_desc),
        .tx_ready (tx_ready),
        .rx_valid (rd_desc_valid),
        .rx_ready (rd_desc_ready),
        .data_out (rd_desc)
    );

    in_wr_ctrl wr_ctrl (
        .external_clk     (external_clk),
        .rst_n            (rst_n),
        .wr_in            (wr_in),
        .fifo_almost_full (almost_full),
        .hs_ready         (hs_ready),
        .crc              (crc),
        .crc_clr          (crc_clr),
        .crc_en           (crc_en),
        .fifo_wr_en       (fifo_wr_en),
        .desc             (wr_desc),
        .desc_valid       (wr_desc_valid),
        .in_ready         (in_ready)
    );

    in_rd_ctrl rd_ctrl (
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .desc         (rd_desc),
        .desc_valid   (rd_desc_valid),
        .desc_ready   (rd_desc_ready),
        .fifo_rd_data (fifo_rd_data),
        .fifo_rd_en   (fifo_rd_en),
        .grant        (grant),
        .ready        (ready),
        .beat         (beat),
        .head         (head)
    );

endmodule

`default_nettype wire

/* verilog/port_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module port_arbiter
    import switch_pkg::*;
(
    input  logic      internal_clk,
    input  logic      rst_n,
    input  out_beat_t beat0,
    input  out_beat_t beat1,
    input  logic      head0,
    input  logic      head1,
    input  logic      out_ready,
    output logic      grant0,
    output logic      grant1,
    output logic      ready0,
    output logic      ready1,
    output out_beat_t pkt_out
);

    arb_state_t        state;
    logic              last;
    logic [PRIO_W-1:0] prio0, prio1;
    logic              pick1;

    assign prio0 = beat0.data[DSC_PRIO_LSB +: PRIO_W];
    assign prio1 = beat1.data[DSC_PRIO_LSB +: PRIO_W];

    // Higher priority wins, a tie goes to the port not served last.
    assign pick1 = head1 & (~head0 | (prio1 > prio0) | ((prio1 == prio0) & ~last));

    always_ff @(posedge internal_clk) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            last  <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (out_ready && (head0 || head1)) begin
                        state <= pick1 ? ARB_PORT1 : ARB_PORT0;
                        last  <= pick1;
                    end
                end
                default: begin
                    if (pkt_out.vld && pkt_out.eop && out_ready) begin
                        state <= ARB_IDLE;   // Packet done.
                    end
                end
            endcase
        end
    end

    assign grant0 = (state == ARB_PORT0);
    assign grant1 = (state == ARB_PORT1);
    assign ready0 = grant0 & out_ready;
    assign ready1 = grant1 & out_ready;

    always_comb begin
        pkt_out = '0;
        if (grant0) begin
            pkt_out     = beat0;
            pkt_out.src = 1'b0;
        end else if (grant1) begin
            pkt_out     = beat1;
            pkt_out.src = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/switch_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_ingress
    import switch_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
)
(
    input  logic      external_clk,
    input  logic      internal_clk,
    input  logic      rst_n,
    input  wr_beat_t  wr_in0,
    input  wr_beat_t  wr_in1,
    output logic      in_ready0,
    output logic      in_ready1,
    output out_beat_t pkt_out,
    input  logic      out_ready
);

    out_beat_t beat0, beat1;
    logic      head0, head1;
    logic      grant0, grant1;
    logic      ready0, ready1;

    in_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) port0 (
        .external_clk (external_clk),
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .wr_in        (wr_in0),
        .in_ready     (in_ready0),
        .beat         (beat0),
        .head         (head0),
        .grant        (grant0),
        .ready        (ready0)
    );

    in_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) port1 (
        .external_clk (external_clk),
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .wr_in        (wr_in1),
        .in_ready     (in_ready1),
        .beat         (beat1),
        .head         (head1),
        .grant        (grant1),
        .ready        (ready1)
    );

    port_arbiter arbiter (
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .beat0        (beat0),
        .beat1        (beat1),
        .head0        (head0),
        .head1        (head1),
        .out_ready    (out_ready),
        .grant0       (grant0),
        .grant1       (grant1),
        .ready0       (ready0),
        .ready1       (ready1),
        .pkt_out      (pkt_out)
    );

endmodule

`default_nettype wire

/* sim/switch_ingress_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_ingress_chk
    import switch_pkg::*;
(
    input logic      internal_clk,
    input logic      rst_n,
    input out_beat_t pkt_out,
    input logic      out_ready,
    input logic      grant0,
    input logic      grant1
);

    vld_known: assert property (@(posedge internal_clk) disable iff (!rst_n)
        !$isunknown(pkt_out.vld))
        else $error("pkt_out.vld is unknown");

    // A stalled beat must not change.
    hold_stable: assert property (@(posedge internal_clk) disable iff (!rst_n)
        (pkt_out.vld && !out_ready) |=> $stable(pkt_out))
        else $error("pkt_out changed while stalled");

    one_grant: assert property (@(posedge internal_clk) disable iff (!rst_n)
        !(grant0 && grant1))
        else $error("Both grants high");

endmodule

bind port_arbiter switch_ingress_chk chk (
    .internal_clk (internal_clk),
    .rst_n        (rst_n),
    .pkt_out      (pkt_out),
    .out_ready    (out_ready),
    .grant0       (grant0),
    .grant1       (grant1)
);

`default_nettype wire

/* sim/switch_ingress_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module switch_ingress_tb
    import switch_pkg::*;
;

    logic      external_clk, internal_clk, rst_n;
    wr_beat_t  wr_in0, wr_in1;
    logic      in_ready0, in_ready1;
    out_beat_t pkt_out;
    logic      out_ready;

    // Expected beats are {sop, eop, dest, data}.
    logic [35:0] exp0[$], exp1[$];
    logic        sop_order[$];
    int          exp_pkts[2], got_pkts[2];
    int          errors, ready_mode;
    logic        in_pkt, cur_src;

    switch_ingress #(.FIFO_DEPTH(64)) dut (
        .external_clk (external_clk),
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .wr_in0       (wr_in0),
        .wr_in1       (wr_in1),
        .in_ready0    (in_ready0),
        .in_ready1    (in_ready1),
        .pkt_out      (pkt_out),
        .out_ready    (out_ready)
    );

    initial begin
        external_clk = 1'b0;
        forever #10 external_clk = ~external_clk;
    end

    initial begin
        internal_clk = 1'b0;
        #7;
        forever #10 internal_clk = ~internal_clk;
    end

    // Folds one word into the CRC MSB first.
    function automatic logic [15:0] crc_fold(input logic [15:0] c, input logic [31:0] w);
        logic msb;
        for (int i = 31; i >= 0; i--) begin
            msb = c[15] ^ w[i];
            c = c << 1;
            if (msb) begin
                c = c ^ 16'h1021;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] desc_word_of(input logic [15:0] crc, input int len,
                                                 input logic [1:0] prio, input logic [1:0] dest);
        logic [31:0] d;
        d = '0;
        d[15:0]  = crc;
        d[20:16] = len[4:0];
        d[22:21] = prio;
        d[24:23] = dest;
        return d;
    endfunction

    task automatic check(input string name, input logic [35:0] got, input logic [35:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout while waiting for %s at %0t ns", what, $time);
        $display("tests failed");
        $finish;
    endtask

    function automatic logic port_ready(input int p);
        return p ? in_ready1 : in_ready0;
    endfunction

    task automatic drive_beat(input int p, input logic vld, input logic sop, input logic eop,
                              input logic [31:0] data);
        wr_beat_t b;
        b.vld  = vld;
        b.sop  = sop;
        b.eop  = eop;
        b.data = data;
        if (p) begin
            wr_in1 = b;
        end else begin
            wr_in0 = b;
        end
    endtask

    task automatic push_expected(input int p, input logic [35:0] b);
        if (p) begin
            exp1.push_back(b);
        end else begin
            exp0.push_back(b);
        end
    endtask

    task automatic send_packet(input int p, input logic [1:0] dest, input logic [1:0] prio,
                               input int hdr_len, input int n_words, input bit gaps);
        logic [31:0] pl [LEN_MAX];
        logic [31:0] hdr;
        logic [15:0] crc;
        int          waited;
        @(negedge external_clk);
        waited = 0;
        while (!port_ready(p)) begin
            @(negedge external_clk);
            waited++;
            if (waited > 4000) begin
                fail_on_timeout("in_ready");
            end
        end
        hdr       = $urandom;   // Upper header bits are ignored.
        hdr[4:0]  = hdr_len[4:0];
        hdr[6:5]  = prio;
        hdr[8:7]  = dest;
        drive_beat(p, 1'b1, 1'b1, n_words == 0, hdr);
        for (int i = 0; i < n_words; i++) begin
            @(negedge external_clk);
            if (gaps && $urandom_range(3, 0) == 0) begin
                drive_beat(p, 1'b0, 1'b0, 1'b0, $urandom);
                @(negedge external_clk);
            end
            pl[i] = $urandom;
            drive_beat(p, 1'b1, 1'b0, i == n_words - 1, pl[i]);
        end
        @(negedge external_clk);
        drive_beat(p, 1'b0, 1'b0, 1'b0, '0);
        if (hdr_len == n_words) begin
            crc = 16'hFFFF;
            for (int i = 0; i < n_words; i++) begin
                crc = crc_fold(crc, pl[i]);
            end
            push_expected(p, {1'b1, n_words == 0, dest, desc_word_of(crc, n_words, prio, dest)});
            for (int i = 0; i < n_words; i++) begin
                push_expected(p, {1'b0, i == n_words - 1, dest, pl[i]});
            end
            exp_pkts[p]++;
        end
    endtask

    task automatic random_traffic(input int p, input int n);
        int len;
        for (int i = 0; i < n; i++) begin
            len = $urandom_range(LEN_MAX, 0);
            send_packet(p, $urandom_range(3, 0), $urandom_range(3, 0), len, len, 1'b1);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp0.size() != 0 || exp1.size() != 0 || in_pkt) begin
            @(posedge internal_clk);
            waited++;
            if (waited > 8000) begin
                fail_on_timeout("the output to drain");
            end
        end
    endtask

    // Both ports loaded while the output is stalled.
    task automatic load_pair(input logic [1:0] prio0, input logic [1:0] prio1);
        ready_mode = 0;
        fork
            send_packet(0, 2'd1, prio0, 3, 3, 1'b0);
            send_packet(1, 2'd2, prio1, 4, 4, 1'b0);
        join
        repeat (60) @(posedge internal_clk);
        ready_mode = 1;
        wait_drain();
    endtask

    always @(negedge internal_clk) begin
        if (ready_mode == 2) begin
            out_ready <= $urandom_range(1, 0);
        end else begin
            out_ready <= (ready_mode == 1);
        end
    end

    // Scoreboard.
    always @(posedge internal_clk) begin : monitor
        logic [35:0] e;
        if (rst_n && pkt_out.vld && out_ready) begin
            if (pkt_out.sop) begin
                if (in_pkt) begin
                    $display("New packet started before eop at %0t ns", $time);
                    errors++;
                end
                cur_src = pkt_out.src;
                sop_order.push_back(pkt_out.src);
            end else if (!in_pkt) begin
                $display("Beat without a packet start at %0t ns", $time);
                errors++;
            end
            check("pkt_out.src", pkt_out.src, cur_src);   // No interleaving.
            if ((pkt_out.src ? exp1.size() : exp0.size()) == 0) begin
                $display("Unexpected beat from port %0d at %0t ns", pkt_out.src, $time);
                errors++;
            end else begin
                e = pkt_out.src ? exp1.pop_front() : exp0.pop_front();
                check("pkt_out", {pkt_out.sop, pkt_out.eop, pkt_out.dest, pkt_out.data}, e);
            end
            in_pkt = ~pkt_out.eop;
            if (pkt_out.eop) begin
                got_pkts[pkt_out.src]++;
            end
        end
    end

    initial begin : main
        wr_in0     = '0;
        wr_in1     = '0;
        out_ready  = 1'b0;
        rst_n      = 1'b0;
        ready_mode = 0;
        errors     = 0;
        in_pkt     = 1'b0;
        cur_src    = 1'b0;
        exp_pkts   = '{0, 0};
        got_pkts   = '{0, 0};
        void'($urandom(82778));
        repeat (4) @(posedge external_clk);
        @(negedge external_clk);
        rst_n = 1'b1;
        ready_mode = 1;

        send_packet(0, 2'd2, 2'd1, 5, 5, 1'b0);
        wait_drain();

        send_packet(0, 2'd1, 2'd0, 6, 3, 1'b0);   // Short packet is dropped.
        send_packet(0, 2'd3, 2'd2, 4, 4, 1'b0);
        wait_drain();

        sop_order.delete();
        load_pair(2'd1, 2'd3);
        check("first src, port 1 higher", sop_order[0], 1'b1);
        sop_order.delete();
        load_pair(2'd2, 2'd0);
        check("first src, port 0 higher", sop_order[0], 1'b0);
        sop_order.delete();
        repeat (3) load_pair(2'd2, 2'd2);
        for (int i = 1; i < sop_order.size(); i++) begin
            check("tie src alternation", sop_order[i], !sop_order[i-1]);
        end

        ready_mode = 2;
        fork
            random_traffic(0, 6);
            random_traffic(1, 6);
        join
        wait_drain();

        fork
            random_traffic(0, 20);
            random_traffic(1, 20);
        join
        wait_drain();

        check("port 0 packet count", got_pkts[0], exp_pkts[0]);
        check("port 1 packet count", got_pkts[1], exp_pkts[1]);
        $display("Closing: %0d errors, %0d packets from port 0, %0d from port 1",
                 errors, got_pkts[0], got_pkts[1]);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/switch_pkg.sv
verilog/crc16_word.sv
verilog/dc_fifo.sv
verilog/cdc_handshake.sv
verilog/in_wr_ctrl.sv
verilog/in_rd_ctrl.sv
verilog/in_port.sv
verilog/port_arbiter.sv
verilog/switch_ingress.sv
sim/switch_ingress_chk.sv
sim/switch_ingress_tb.sv
